// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

   // ==================================================
   // Bus widths
   // ==================================================

   // Data and address share one width on this bus
   localparam int data_width = 32;

   // ==================================================
   // Transfer encodings
   // ==================================================

   // Only single transfers are issued, so no busy or seq
   typedef enum logic [1:0] {
      htrans_idle   = 2'b00,
      htrans_nonseq = 2'b10
   } htrans_t;

   // Transfer size as driven on hsize
   typedef enum logic [2:0] {
      hsize_byte = 3'd0,
      hsize_half = 3'd1,
      hsize_word = 3'd2
   } hsize_t;

   // ==================================================
   // Address phase
   // ==================================================

   // Everything the master drives during one address phase
   typedef struct packed {
      htrans_t                 htrans;
      logic                    hwrite;
      hsize_t                  hsize;
      logic [data_width-1:0]   haddr;
   } bus_addr_t;

endpackage : bus_pkg

`default_nettype wire

// File: data_phase_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module data_phase_tracker
   import bus_pkg::*;
   import lsu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    hready,
   input  lsu_req_t                req,
   input  logic [data_width-1:0]   wdata_aligned,
   output phase_ctx_t              ctx,
   output logic [data_width-1:0]   hwdata
);

   // ==================================================
   // Address to data phase hand-over
   // ==================================================

   // An address phase completes on every edge with hready high.
   // Whatever sits on req then moves into the data phase; an idle
   // cycle simply leaves an invalid context behind.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctx.valid       <= 1'b0;
         ctx.write       <= 1'b0;
         ctx.size        <= size_byte;
         ctx.is_unsigned <= 1'b0;
         ctx.addr_lo     <= 2'b00;
         ctx.rd          <= '0;
         hwdata          <= '0;
      end else if (hready) begin
         ctx.valid       <= req.valid;
         ctx.write       <= req.write;
         ctx.size        <= req.size;
         ctx.is_unsigned <= req.is_unsigned;
         // Only the lane offset matters for load extraction
         ctx.addr_lo     <= req.addr[1:0];
         ctx.rd          <= req.rd;
         // Store data follows its address one phase later
         hwdata          <= wdata_aligned;
      end
   end

endmodule : data_phase_tracker

`default_nettype wire

// File: load_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module load_extractor
   import bus_pkg::*;
   import lsu_pkg::*;
(
   input  phase_ctx_t              ctx,
   input  logic [data_width-1:0]   hrdata,
   input  logic                    hready,
   output wb_t                     wb
);

   logic [data_width-1:0] byte_shift;
   logic [data_width-1:0] half_shift;
   logic [7:0]            ld_byte;
   logic [15:0]           ld_half;
   logic [data_width-1:0] ld_data;

   // ==================================================
   // Lane selection
   // ==================================================

   // Bring the addressed lane down to bit 0
   assign byte_shift = hrdata >> {ctx.addr_lo, 3'b000};
   assign half_shift = hrdata >> {ctx.addr_lo[1], 4'b0000};
   assign ld_byte    = byte_shift[7:0];
   assign ld_half    = half_shift[15:0];

   // Sign or zero extension
   always_comb begin
      case (ctx.size)
         size_byte: begin
            ld_data = {{(data_width-8){ld_byte[7] & ~ctx.is_unsigned}}, ld_byte};
         end
         size_half: begin
            ld_data = {{(data_width-16){ld_half[15] & ~ctx.is_unsigned}}, ld_half};
         end
         default: begin
            ld_data = hrdata;
         end
      endcase
   end

   // ==================================================
   // Write-back record
   // ==================================================

   // Data is only sampled on the edge that closes the data phase
   always_comb begin
      wb.valid = ctx.valid & ~ctx.write & hready;
      wb.rd    = ctx.rd;
      wb.data  = ld_data;
   end

endmodule : load_extractor

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   import bus_pkg::*;

   // Destination register index
   localparam int rd_width = 5;

   // Access size as seen by the requester
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_t;

   // One access presented by execute
   typedef struct packed {
      logic                    valid;
      logic                    write;
      access_size_t            size;
      logic                    is_unsigned;
      logic [data_width-1:0]   addr;
      logic [data_width-1:0]   wdata;
      logic [rd_width-1:0]     rd;
   } lsu_req_t;

   // Bookkeeping for the access sitting in its data phase
   typedef struct packed {
      logic                    valid;
      logic                    write;
      access_size_t            size;
      logic                    is_unsigned;
      logic [1:0]              addr_lo;
      logic [rd_width-1:0]     rd;
   } phase_ctx_t;

   // Load result headed for the register file
   typedef struct packed {
      logic                    valid;
      logic [rd_width-1:0]     rd;
      logic [data_width-1:0]   data;
   } wb_t;

endpackage : lsu_pkg

`default_nettype wire

// File: lsu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sva
   import bus_pkg::*;
   import lsu_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input bus_addr_t  bus,
   input logic       hready,
   input wb_t        wb
);

   // Load whose address phase completes on this edge
   logic load_accepted;

   assign load_accepted = hready && (bus.htrans == htrans_nonseq) && !bus.hwrite;

   // Address phase must hold while the slave stretches it
   addr_hold_a: assert property (
      @(posedge clk) disable iff (!rst_n)
      (bus.htrans == htrans_nonseq && !hready) |=> $stable(bus)
   ) else $error("address phase changed during a wait state");

   // A load with no wait state writes back on the very next edge
   load_wb_a: assert property (
      @(posedge clk) disable iff (!rst_n)
      (hready && $past(load_accepted)) |-> wb.valid
   ) else $error("load data phase ended without a write-back");

   // Stores and idle slots never write back
   no_load_no_wb_a: assert property (
      @(posedge clk) disable iff (!rst_n)
      ($past(hready) && !$past(load_accepted)) |-> !wb.valid
   ) else $error("write-back raised without a load in its data phase");

endmodule : lsu_sva

bind lsu_top lsu_sva u_lsu_sva (
   .clk    (clk),
   .rst_n  (rst_n),
   .bus    (bus),
   .hready (hready),
   .wb     (wb)
);

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
   import bus_pkg::*;
   import lsu_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   // Requester side
   input  lsu_req_t                req,
   output logic                    req_ready,
   // Data bus
   output bus_addr_t               bus,
   output logic [data_width-1:0]   hwdata,
   input  logic [data_width-1:0]   hrdata,
   input  logic                    hready,
   // Write-back
   output wb_t                     wb
);

   logic [data_width-1:0] wdata_aligned;
   phase_ctx_t            ctx;

   // A new access can only be taken when the bus accepts
   // the address phase
   assign req_ready = hready;

   // ==================================================
   // Address phase
   // ==================================================

   store_aligner u_store_aligner (
      .req           (req),
      .bus           (bus),
      .wdata_aligned (wdata_aligned)
   );

   // ==================================================
   // Data phase
   // ==================================================

   data_phase_tracker u_data_phase_tracker (
      .clk           (clk),
      .rst_n         (rst_n),
      .hready        (hready),
      .req           (req),
      .wdata_aligned (wdata_aligned),
      .ctx           (ctx),
      .hwdata        (hwdata)
   );

   // Load return path
   load_extractor u_load_extractor (
      .ctx           (ctx),
      .hrdata        (hrdata),
      .hready        (hready),
      .wb            (wb)
   );

endmodule : lsu_top

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_lsu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1

// File: src.f
bus_pkg.sv
lsu_pkg.sv
store_aligner.sv
data_phase_tracker.sv
load_extractor.sv
lsu_top.sv
lsu_sva.sv
tb_lsu.sv

// File: store_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module store_aligner
   import bus_pkg::*;
   import lsu_pkg::*;
(
   input  lsu_req_t                req,
   output bus_addr_t               bus,
   output logic [data_width-1:0]   wdata_aligned
);

   // ==================================================
   // Address phase
   // ==================================================

   always_comb begin
      bus.htrans = req.valid ? htrans_nonseq : htrans_idle;
      bus.hwrite = req.write;
      bus.haddr  = req.addr;

      case (req.size)
         size_byte: begin
            bus.hsize = hsize_byte;
         end
         size_half: begin
            bus.hsize = hsize_half;
         end
         default: begin
            bus.hsize = hsize_word;
         end
      endcase
   end

   // ==================================================
   // Store lane placement
   // ==================================================

   // Requester guarantees natural alignment, so a halfword
   // only ever lands in the low or the high half
   always_comb begin
      case (req.size)
         size_byte: begin
            // Byte goes to lane addr[1:0] and the rest stays zero
            wdata_aligned = data_width'(req.wdata[7:0]) << {req.addr[1:0], 3'b000};
         end
         size_half: begin
            wdata_aligned = data_width'(req.wdata[15:0]) << {req.addr[1], 4'b0000};
         end
         default: begin
            // Full word needs no shifting
            wdata_aligned = req.wdata;
         end
      endcase
   end

endmodule : store_aligner

`default_nettype wire

// File: tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
   import bus_pkg::*;
   import lsu_pkg::*;
();

   localparam int          n_ops      = 400;
   localparam int          max_cycles = n_ops * 5 + 100;
   localparam logic [31:0] seed       = 32'h3038_4dd7;

   logic                  clk;
   logic                  rst_n;
   lsu_req_t              req;
   logic                  req_ready;
   bus_addr_t             bus;
   logic [data_width-1:0] hwdata;
   logic [data_width-1:0] hrdata;
   logic                  hready;
   wb_t                   wb;

   logic [31:0] lfsr;
   logic [31:0] bus_mem [0:15];
   logic [31:0] ref_mem [0:15];
   logic [36:0] exp_q [$];
   logic [31:0] store_q [$];
   logic [36:0] exp_item;
   bus_addr_t   dp;
   logic        dp_valid;
   int          wait_left;
   int          n_issued;
   int          cycle_count;
   int          err_count;
   int          check_count;
   logic        running;
   lsu_req_t    next_req;
   logic [31:0] wait_bits;

   lsu_top u_lsu_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_ready (req_ready),
      .bus       (bus),
      .hwdata    (hwdata),
      .hrdata    (hrdata),
      .hready    (hready),
      .wb        (wb)
   );

   // ==================================================
   // Helpers
   // ==================================================

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Start contents differ in every word
   function automatic logic [31:0] fill_word(input int idx);
      return (32'h9e37_79b9 * (idx + 1)) ^ {4{idx[7:0]}};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // Mostly valid accesses with roughly one idle slot in eight
   task automatic make_request(output lsu_req_t r);
      logic [31:0] v;
      r = '0;
      take_bits(3, v);
      r.valid = (v[2:0] != 3'd0);
      take_bits(1, v);
      r.write = v[0];
      take_bits(2, v);
      r.size = (v[1:0] == 2'd3) ? size_word : access_size_t'(v[1:0]);
      take_bits(1, v);
      r.is_unsigned = v[0];
      take_bits(6, v);
      case (r.size)
         size_byte: r.addr = {26'd0, v[5:0]};
         size_half: r.addr = {26'd0, v[5:1], 1'b0};
         default:   r.addr = {26'd0, v[5:2], 2'b00};
      endcase
      take_bits(32, v);
      r.wdata = v;
      take_bits(5, v);
      r.rd = v[4:0];
   endtask

   // Reference memory follows the accepted request stream in order
   task automatic model_accept(input lsu_req_t r);
      int          widx;
      int          off;
      int          nbytes;
      logic [31:0] word;
      logic [31:0] val;
      logic [31:0] wdata_exp;
      widx      = int'(r.addr[5:2]);
      off       = int'(r.addr[1:0]);
      nbytes    = (r.size == size_byte) ? 1 : (r.size == size_half) ? 2 : 4;
      wdata_exp = '0;
      if (r.write) begin
         for (int i = 0; i < nbytes; i++) begin
            ref_mem[widx][(off + i) * 8 +: 8] = r.wdata[i * 8 +: 8];
            wdata_exp[(off + i) * 8 +: 8]     = r.wdata[i * 8 +: 8];
         end
         store_q.push_back(wdata_exp);
      end else begin
         word = ref_mem[widx];
         val  = word;
         if (nbytes == 1) begin
            val = {24'd0, word[off * 8 +: 8]};
            if (!r.is_unsigned && val[7]) begin
               val = val | 32'hffff_ff00;
            end
         end else if (nbytes == 2) begin
            val = {16'd0, word[off * 8 +: 16]};
            if (!r.is_unsigned && val[15]) begin
               val = val | 32'hffff_0000;
            end
         end
         exp_q.push_back({r.rd, val});
      end
   endtask

   // ==================================================
   // Clock and run limit
   // ==================================================

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("Test failed");
         $finish;
      end
   end

   // ==================================================
   // Bus slave and requester
   // ==================================================

   always @(posedge clk) begin
      if (rst_n) begin
         check_value("bus.htrans", 32'(bus.htrans),
                     req.valid ? 32'(htrans_nonseq) : 32'(htrans_idle));
         if (hready) begin
            // Data phase ends here, stores land in memory
            if (dp_valid && dp.hwrite) begin
               if (store_q.size() == 0) begin
                  err_count++;
                  $display("Store data phase at %0t ns with no store outstanding", $time);
               end else begin
                  check_value("hwdata", hwdata, store_q.pop_front());
               end
               for (int i = 0; i < (1 << int'(dp.hsize)); i++) begin
                  bus_mem[dp.haddr[5:2]][(int'(dp.haddr[1:0]) + i) * 8 +: 8] =
                     hwdata[(int'(dp.haddr[1:0]) + i) * 8 +: 8];
               end
            end
            dp        = bus;
            dp_valid  = (bus.htrans == htrans_nonseq);
            wait_left = 0;
            if (dp_valid) begin
               take_bits(2, wait_bits);
               wait_left = int'(wait_bits[1:0]);
            end
            hready <= (wait_left == 0);
            hrdata <= bus_mem[bus.haddr[5:2]];
         end else begin
            wait_left--;
            hready <= (wait_left == 0);
         end

         if (req.valid && req_ready) begin
            check_value("bus.hwrite", 32'(bus.hwrite), 32'(req.write));
            check_value("bus.hsize", 32'(bus.hsize),
                        (req.size == size_byte) ? 32'd0 :
                        (req.size == size_half) ? 32'd1 : 32'd2);
            check_value("bus.haddr", bus.haddr, req.addr);
            model_accept(req);
         end
         if (req_ready) begin
            if (running && n_issued < n_ops) begin
               make_request(next_req);
               if (next_req.valid) begin
                  n_issued++;
               end
               req <= next_req;
            end else begin
               req <= '0;
            end
         end
      end
   end

   // Write-back is combinational so look at it mid-cycle
   always @(negedge clk) begin
      if (rst_n && wb.valid) begin
         if (exp_q.size() == 0) begin
            err_count++;
            $display("Unexpected write-back at %0t ns with no load outstanding", $time);
         end else begin
            exp_item = exp_q.pop_front();
            check_value("wb.rd", 32'(wb.rd), 32'(exp_item[36:32]));
            check_value("wb.data", wb.data, exp_item[31:0]);
         end
      end
   end

   // ==================================================
   // Sequence
   // ==================================================

   initial begin
      rst_n       = 1'b0;
      req         = '0;
      hready      = 1'b1;
      hrdata      = '0;
      dp          = '0;
      dp_valid    = 1'b0;
      wait_left   = 0;
      n_issued    = 0;
      cycle_count = 0;
      err_count   = 0;
      check_count = 0;
      running     = 1'b0;
      lfsr        = seed;
      for (int i = 0; i < 16; i++) begin
         bus_mem[i] = fill_word(i);
         ref_mem[i] = fill_word(i);
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Quiet bus before the first request
      @(negedge clk);
      check_value("bus.htrans", 32'(bus.htrans), 32'(htrans_idle));
      check_value("wb.valid", 32'(wb.valid), 32'd0);
      running = 1'b1;

      wait (n_issued == n_ops);
      @(negedge clk);
      while (req.valid || dp_valid) @(negedge clk);
      repeat (2) @(negedge clk);
      if (exp_q.size() != 0) begin
         err_count++;
         $display("%0d loads never returned a write-back", exp_q.size());
      end
      if (store_q.size() != 0) begin
         err_count++;
         $display("%0d stores never reached the end of their data phase", store_q.size());
      end
      for (int i = 0; i < 16; i++) begin
         check_value($sformatf("bus_mem[%0d]", i), bus_mem[i], ref_mem[i]);
      end

      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : tb_lsu

`default_nettype wire
